/* src/ram_pkg.sv */
package ram_pkg;

	// **********************************************************************
	// Geometry of the scratch memory.
	// **********************************************************************

	localparam int addr_w = 8;
	localparam int data_w = 16;
	localparam int num_words = 256;

	// **********************************************************************
	// Channel sizing.
	// **********************************************************************

	// Queue entries, also the requester's credits after reset.
	localparam int req_depth = 4;

	// Response credits held by the sequencer after reset.
	localparam int rsp_credits = 2;

	// Derived widths for pointers and counters.
	localparam int req_ptr_w = $clog2(req_depth);
	localparam int req_cnt_w = $clog2(req_depth + 1);
	localparam int rsp_cnt_w = $clog2(rsp_credits + 1);

	// **********************************************************************
	// Request and response formats.
	// **********************************************************************

	typedef enum logic {
		op_read  = 1'b0,
		op_write = 1'b1
	} ram_op_e;

	// Data words follow the RAM numbering, bit 0 is the MSB.
	typedef struct packed {
		ram_op_e             op;
		logic [addr_w-1:0]   addr;
		logic [0:data_w-1]   wdata;
	} ram_req_t;

	typedef struct packed {
		logic [addr_w-1:0]   addr;
		logic [0:data_w-1]   rdata;
	} ram_rsp_t;

endpackage

/* src/req_queue.sv */
module req_queue (
	input  logic               sys_clk,
	input  logic               rst_n,
	input  logic               req_valid,
	input  ram_pkg::ram_req_t  req,
	input  logic               q_pop,
	output logic               req_credit,
	output logic               q_valid,
	output ram_pkg::ram_req_t  q_head
);

	ram_pkg::ram_req_t                entries [ram_pkg::req_depth];
	logic [ram_pkg::req_ptr_w-1:0]    wr_ptr;
	logic [ram_pkg::req_ptr_w-1:0]    rd_ptr;
	logic [ram_pkg::req_cnt_w-1:0]    count;
	logic                             full;

	// **********************************************************************
	// Storage and pointers.
	// **********************************************************************

	// Entry payload, no reset needed.
	always_ff @(posedge sys_clk) begin
		if (req_valid) begin
			entries[wr_ptr] <= req;
		end
	end

	// Depth is a power of two, pointers wrap on their own.
	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (req_valid) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (q_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// Occupancy.
	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			count <= '0;
		end else begin
			case ({req_valid, q_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// One credit back to the requester per pop, a cycle later.
	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			req_credit <= 1'b0;
		end else begin
			req_credit <= q_pop;
		end
	end

	assign full    = (count == ram_pkg::req_cnt_w'(ram_pkg::req_depth));
	assign q_valid = (count != '0);
	assign q_head  = entries[rd_ptr];

	// A push into a full queue means the requester spent a credit it never had.
	a_no_overflow: assert property (
		@(posedge sys_clk) disable iff (!rst_n)
		req_valid |-> !full
	) else $error("req_queue: push while full, credit protocol violated");

endmodule

/* src/access_sequencer.sv */
module access_sequencer (
	input  logic                        sys_clk,
	input  logic                        rst_n,
	input  logic                        q_valid,
	input  ram_pkg::ram_req_t           q_head,
	input  logic [0:ram_pkg::data_w-1]  z_out,
	input  logic [0:ram_pkg::data_w-1]  z_oe,
	input  logic                        rsp_credit,
	output logic                        q_pop,
	output logic                        cen,
	output logic                        rw,
	output logic [0:ram_pkg::addr_w-1]  a,
	output logic [0:ram_pkg::data_w-1]  z_in,
	output logic                        rsp_valid,
	output ram_pkg::ram_rsp_t           rsp
);

	logic [ram_pkg::rsp_cnt_w-1:0]  credit_cnt;
	logic [ram_pkg::addr_w-1:0]     rd_addr;
	logic                           is_read;
	logic                           have_credit;
	logic                           issue_read;

	// **********************************************************************
	// Pop decision.
	// **********************************************************************

	// Writes never wait.
	// A read needs a response credit, spent at issue time.
	always_comb begin
		is_read     = (q_head.op == ram_pkg::op_read);
		have_credit = (credit_cnt != '0);
		q_pop       = q_valid && (!is_read || have_credit);
		issue_read  = q_pop && is_read;
	end

	// **********************************************************************
	// RAM pins.
	// **********************************************************************

	// One RAM cycle per pop, driven straight from the queue head.
	assign cen  = !q_pop;
	assign rw   = is_read;
	assign a    = q_head.addr;
	assign z_in = q_head.wdata;

	// **********************************************************************
	// Read tracking and response.
	// **********************************************************************

	// Address of the read now in the RAM pipeline.
	// Only one read can be in flight, since its data returns next cycle.
	always_ff @(posedge sys_clk) begin
		if (issue_read) begin
			rd_addr <= q_head.addr;
		end
	end

	// Output enable from the RAM marks the cycle the read word is valid.
	assign rsp_valid = &z_oe;

	always_comb begin
		rsp.addr  = rd_addr;
		rsp.rdata = z_out;
	end

	// **********************************************************************
	// Response credits.
	// **********************************************************************

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			credit_cnt <= ram_pkg::rsp_cnt_w'(ram_pkg::rsp_credits);
		end else begin
			case ({issue_read, rsp_credit})
				2'b10:   credit_cnt <= credit_cnt - 1'b1;
				2'b01:   credit_cnt <= credit_cnt + 1'b1;
				default: credit_cnt <= credit_cnt;
			endcase
		end
	end

	// The consumer may never hand back more credits than it was given.
	a_credit_bound: assert property (
		@(posedge sys_clk) disable iff (!rst_n)
		credit_cnt <= ram_pkg::rsp_cnt_w'(ram_pkg::rsp_credits)
	) else $error("access_sequencer: response credits above %0d", ram_pkg::rsp_credits);

endmodule

/* src/sram_256x16.sv */
module sram_256x16 (
	input  logic                        sys_clk,
	input  logic                        rst_n,
	input  logic                        cen,
	input  logic                        rw,
	input  logic [0:ram_pkg::addr_w-1]  a,
	input  logic [0:ram_pkg::data_w-1]  z_in,
	output logic [0:ram_pkg::data_w-1]  z_out,
	output logic [0:ram_pkg::data_w-1]  z_oe
);

	logic [ram_pkg::data_w-1:0]  ram_blk [ram_pkg::num_words];
	logic [ram_pkg::addr_w-1:0]  a_r;
	logic [ram_pkg::data_w-1:0]  z_in_r;
	logic [ram_pkg::data_w-1:0]  z_out_r;

	// Big-endian pins to little-endian internals and back.
	always_comb begin
		for (int i = 0; i < ram_pkg::addr_w; i++) begin
			a_r[ram_pkg::addr_w-1-i] = a[i];
		end
		for (int i = 0; i < ram_pkg::data_w; i++) begin
			z_in_r[ram_pkg::data_w-1-i] = z_in[i];
			z_out[i] = z_out_r[ram_pkg::data_w-1-i];
		end
	end

	// Powers up cleared.
	initial begin
		for (int i = 0; i < ram_pkg::num_words; i++) begin
			ram_blk[i] = '0;
		end
	end

	// Write-first, a read colliding with a write sees the new word.
	always_ff @(posedge sys_clk) begin
		if (!cen) begin
			if (!rw) begin
				ram_blk[a_r] <= z_in_r;
				z_out_r      <= z_in_r;
			end else begin
				z_out_r      <= ram_blk[a_r];
			end
		end
	end

	// Output enable for one cycle after each read.
	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			z_oe <= '0;
		end else begin
			z_oe <= (!cen && rw) ? '1 : '0;
		end
	end

	a_addr_known: assert property (
		@(posedge sys_clk) disable iff (!rst_n)
		!cen |-> !$isunknown(a)
	) else $error("sram_256x16: unknown address on an enabled cycle");

endmodule

/* src/scratch_ram_top.sv */
module scratch_ram_top (
	input  logic               sys_clk,
	input  logic               rst_n,
	input  logic               req_valid,
	input  ram_pkg::ram_req_t  req,
	input  logic               rsp_credit,
	output logic               req_credit,
	output logic               rsp_valid,
	output ram_pkg::ram_rsp_t  rsp
);

	// **********************************************************************
	// Queue to sequencer.
	// **********************************************************************

	logic               q_valid;
	logic               q_pop;
	ram_pkg::ram_req_t  q_head;

	// **********************************************************************
	// Sequencer to RAM pins.
	// **********************************************************************

	logic                        cen;
	logic                        rw;
	logic [0:ram_pkg::addr_w-1]  a;
	logic [0:ram_pkg::data_w-1]  z_in;
	logic [0:ram_pkg::data_w-1]  z_out;
	logic [0:ram_pkg::data_w-1]  z_oe;

	req_queue u_req_queue (
		.sys_clk    (sys_clk),
		.rst_n      (rst_n),
		.req_valid  (req_valid),
		.req        (req),
		.q_pop      (q_pop),
		.req_credit (req_credit),
		.q_valid    (q_valid),
		.q_head     (q_head)
	);

	access_sequencer u_access_sequencer (
		.sys_clk    (sys_clk),
		.rst_n      (rst_n),
		.q_valid    (q_valid),
		.q_head     (q_head),
		.z_out      (z_out),
		.z_oe       (z_oe),
		.rsp_credit (rsp_credit),
		.q_pop      (q_pop),
		.cen        (cen),
		.rw         (rw),
		.a          (a),
		.z_in       (z_in),
		.rsp_valid  (rsp_valid),
		.rsp        (rsp)
	);

	sram_256x16 u_sram_256x16 (
		.sys_clk (sys_clk),
		.rst_n   (rst_n),
		.cen     (cen),
		.rw      (rw),
		.a       (a),
		.z_in    (z_in),
		.z_out   (z_out),
		.z_oe    (z_oe)
	);

endmodule

/* bench/tb_scratch_ram.sv */
module tb_scratch_ram;

	// **********************************************************************
	// Test sizing and run limit.
	// **********************************************************************

	localparam int n_zero_reads   = 16;
	localparam int n_readback     = 37;
	localparam int n_burst        = 8;
	localparam int n_random       = 300;
	localparam int n_backpressure = 6;
	localparam int n_same_addr    = 16;
	localparam int total_reqs     = n_zero_reads + n_readback + n_burst + n_random
		+ n_backpressure + n_same_addr;
	localparam int wd_cycles      = total_reqs * 200 + 2000;

	// Cycles allowed for the last credits of a burst to come home.
	localparam int credit_wait    = ram_pkg::req_depth + 4;

	logic               sys_clk;
	logic               rst_n;
	logic               req_valid;
	ram_pkg::ram_req_t  req;
	logic               rsp_credit;
	logic               req_credit;
	logic               rsp_valid;
	ram_pkg::ram_rsp_t  rsp;

	// Memory model and the expected responses in request order.
	logic [ram_pkg::data_w-1:0]  model_mem [ram_pkg::num_words];
	ram_pkg::ram_rsp_t           exp_list [$];

	integer  seed;
	int      reqs_sent;
	int      credits_returned;
	int      rsp_seen;
	int      rsp_returned;
	int      check_errors;
	int      flow_errors;
	int      tests_run;
	int      tests_failed;
	int      max_outstanding;
	logic    hold_rsp;

	scratch_ram_top dut (
		.sys_clk    (sys_clk),
		.rst_n      (rst_n),
		.req_valid  (req_valid),
		.req        (req),
		.rsp_credit (rsp_credit),
		.req_credit (req_credit),
		.rsp_valid  (rsp_valid),
		.rsp        (rsp)
	);

	initial begin
		sys_clk = 1'b0;
		forever begin
			#10 sys_clk = ~sys_clk;
		end
	end

	// **********************************************************************
	// Reference model and requester helpers.
	// **********************************************************************

	// Expected response for a read issued now.
	function automatic ram_pkg::ram_rsp_t expected_rsp(input logic [ram_pkg::addr_w-1:0] addr);
		ram_pkg::ram_rsp_t r;
		r.addr  = addr;
		r.rdata = model_mem[addr];
		return r;
	endfunction

	function automatic int total_errors();
		return check_errors + flow_errors;
	endfunction

	// Waits for a request credit, then drives one request for one cycle.
	task automatic send_req(input ram_pkg::ram_op_e op, input logic [ram_pkg::addr_w-1:0] addr,
		input logic [ram_pkg::data_w-1:0] wdata);
		ram_pkg::ram_req_t r;
		// Requests in flight if this one could go out right away.
		if (reqs_sent - credits_returned + 1 > max_outstanding) begin
			max_outstanding = reqs_sent - credits_returned + 1;
		end
		while (reqs_sent - credits_returned >= ram_pkg::req_depth) begin
			@(negedge sys_clk);
		end
		r.op    = op;
		r.addr  = addr;
		r.wdata = wdata;
		if (op == ram_pkg::op_write) begin
			model_mem[addr] = wdata;
		end else begin
			exp_list.push_back(expected_rsp(addr));
		end
		req       = r;
		req_valid = 1'b1;
		reqs_sent++;
		@(negedge sys_clk);
		req_valid = 1'b0;
	endtask

	// All reads answered, all credits home on both channels.
	task automatic drain_outstanding();
		while (rsp_seen != exp_list.size() || credits_returned != reqs_sent
			|| rsp_returned != rsp_seen) begin
			@(negedge sys_clk);
		end
		@(negedge sys_clk);
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests_run++;
		if (total_errors() == errs_before) begin
			$display("PASS  %s", name);
		end else begin
			tests_failed++;
			$display("FAIL  %s (%0d errors)", name, total_errors() - errs_before);
		end
	endtask

	// **********************************************************************
	// Response checker and credit monitor.
	// **********************************************************************

	initial begin
		credits_returned = 0;
		rsp_seen         = 0;
		check_errors     = 0;
		forever begin
			@(posedge sys_clk);
			if (req_credit === 1'b1) begin
				credits_returned++;
				if (credits_returned > reqs_sent) begin
					$display("Error at %0t: req_credit returned with no request outstanding",
						$time);
					check_errors++;
				end
			end
			if (rsp_valid === 1'b1) begin
				if (rsp_seen >= exp_list.size()) begin
					$display("Error at %0t: response arrived with no read outstanding", $time);
					check_errors++;
				end else begin
					if (rsp.addr !== exp_list[rsp_seen].addr) begin
						$display("MISMATCH at %0t: rsp.addr expected %h got %h", $time,
							exp_list[rsp_seen].addr, rsp.addr);
						check_errors++;
					end
					if (rsp.rdata !== exp_list[rsp_seen].rdata) begin
						$display("MISMATCH at %0t: rsp.rdata expected %h got %h", $time,
							exp_list[rsp_seen].rdata, rsp.rdata);
						check_errors++;
					end
				end
				rsp_seen++;
			end
		end
	end

	// Consumer hands back one response credit per response unless held.
	initial begin
		rsp_credit   = 1'b0;
		rsp_returned = 0;
		forever begin
			@(negedge sys_clk);
			if (rst_n && !hold_rsp && rsp_returned < rsp_seen) begin
				rsp_credit = 1'b1;
				rsp_returned++;
			end else begin
				rsp_credit = 1'b0;
			end
		end
	end

	initial begin
		repeat (wd_cycles) @(posedge sys_clk);
		$display("Watchdog expired after %0d cycles, %0d of %0d responses received",
			wd_cycles, rsp_seen, exp_list.size());
		$display("Test failures found");
		$finish;
	end

	// **********************************************************************
	// Stimulus.
	// **********************************************************************

	initial begin
		int                          errs_before;
		int                          hold_base;
		int                          wait_cycles;
		logic [0:ram_pkg::data_w-1]  be_word;
		logic [ram_pkg::addr_w-1:0]  addr;
		logic [ram_pkg::data_w-1:0]  data;
		seed            = 12111;
		rst_n           = 1'b0;
		req_valid       = 1'b0;
		req             = '0;
		hold_rsp        = 1'b0;
		reqs_sent       = 0;
		flow_errors     = 0;
		tests_run       = 0;
		tests_failed    = 0;
		max_outstanding = 0;
		for (int i = 0; i < ram_pkg::num_words; i++) begin
			model_mem[i] = '0;
		end
		repeat (3) @(posedge sys_clk);
		@(negedge sys_clk);
		rst_n = 1'b1;

		// Idle after reset, then a sample of reads that must all be zero.
		errs_before = total_errors();
		repeat (5) @(negedge sys_clk);
		if (credits_returned != 0 || rsp_seen != 0) begin
			$display("Error at %0t: credit or response seen before any request", $time);
			flow_errors++;
		end
		for (int i = 0; i < n_zero_reads; i++) begin
			send_req(ram_pkg::op_read, 8'(i * 17), '0);
		end
		drain_outstanding();
		finish_test("reset state and zero reads", errs_before);

		// Writes, single-bit words, one overwrite, then read-back.
		errs_before = total_errors();
		for (int i = 0; i < 16; i++) begin
			send_req(ram_pkg::op_write, 8'(i * 13 + 3), 16'($random(seed)));
		end
		be_word    = '0;
		be_word[0] = 1'b1;
		send_req(ram_pkg::op_write, 8'hf0, be_word);
		be_word     = '0;
		be_word[15] = 1'b1;
		send_req(ram_pkg::op_write, 8'hf1, be_word);
		send_req(ram_pkg::op_write, 8'h03, 16'hc3a5);
		for (int i = 0; i < 16; i++) begin
			send_req(ram_pkg::op_read, 8'(i * 13 + 3), '0);
		end
		send_req(ram_pkg::op_read, 8'hf0, '0);
		send_req(ram_pkg::op_read, 8'hf1, '0);
		drain_outstanding();
		finish_test("write then read-back", errs_before);

		// Back-to-back writes, every credit must come home.
		errs_before     = total_errors();
		max_outstanding = 0;
		for (int i = 0; i < n_burst; i++) begin
			send_req(ram_pkg::op_write, 8'(8'h80 + i), 16'($random(seed)));
		end
		wait_cycles = 0;
		while (credits_returned != reqs_sent && wait_cycles < credit_wait) begin
			@(negedge sys_clk);
			wait_cycles++;
		end
		@(negedge sys_clk);
		if (credits_returned != reqs_sent) begin
			$display("Error at %0t: %0d requests sent but %0d credits returned", $time,
				reqs_sent, credits_returned);
			flow_errors++;
		end
		if (max_outstanding > ram_pkg::req_depth) begin
			$display("Error at %0t: %0d requests needed in flight, queue holds %0d", $time,
				max_outstanding, ram_pkg::req_depth);
			flow_errors++;
		end
		finish_test("credit conservation", errs_before);

		errs_before = total_errors();
		for (int i = 0; i < n_random; i++) begin
			addr = 8'($random(seed));
			data = 16'($random(seed));
			if (($random(seed) & 1) != 0) begin
				send_req(ram_pkg::op_write, addr, data);
			end else begin
				send_req(ram_pkg::op_read, addr, '0);
			end
		end
		drain_outstanding();
		finish_test("random mixed traffic", errs_before);

		// Consumer withholds credits until the request queue is full.
		errs_before = total_errors();
		hold_rsp    = 1'b1;
		hold_base   = rsp_seen;
		for (int i = 0; i < n_backpressure; i++) begin
			send_req(ram_pkg::op_read, 8'(8'h80 + i), '0);
		end
		while (reqs_sent - credits_returned < ram_pkg::req_depth) begin
			@(negedge sys_clk);
		end
		repeat (10) @(negedge sys_clk);
		if (rsp_seen - hold_base != ram_pkg::rsp_credits) begin
			$display("Error at %0t: %0d responses while credits were held, expected %0d",
				$time, rsp_seen - hold_base, ram_pkg::rsp_credits);
			flow_errors++;
		end
		hold_rsp = 1'b0;
		drain_outstanding();
		finish_test("response back-pressure", errs_before);

		// Read straight after a write to the same word.
		errs_before = total_errors();
		for (int i = 0; i < n_same_addr / 2; i++) begin
			addr = 8'($random(seed));
			send_req(ram_pkg::op_write, addr, 16'($random(seed)));
			send_req(ram_pkg::op_read, addr, '0);
		end
		drain_outstanding();
		finish_test("same-address write then read", errs_before);

		$display("Summary: %0d tests, %0d passed, %0d failed, %0d errors, %0d responses",
			tests_run, tests_run - tests_failed, tests_failed, total_errors(), rsp_seen);
		if (total_errors() == 0 && tests_failed == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

/* vlog.f */
src/ram_pkg.sv
src/req_queue.sv
src/access_sequencer.sv
src/sram_256x16.sv
src/scratch_ram_top.sv
bench/tb_scratch_ram.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
build_log=build.log
sim_log=sim.log

rm -f "$build_log" "$sim_log"

verilator --binary --timing --assert -f vlog.f --top-module tb_scratch_ram \
	--Mdir "$build_dir" -o sim_tb > "$build_log" 2>&1 \
	&& "./$build_dir/sim_tb" > "$sim_log" 2>&1 \
	|| { cat "$build_log" "$sim_log" 2>/dev/null; echo "Build or run failed"; exit 1; }

cat "$sim_log"

grep -q 'All tests passed!' "$sim_log" \
	&& { echo "Simulation PASSED"; exit 0; } \
	|| { echo "Simulation FAILED"; exit 1; }
